// ==== source/eth_rx_pkg.sv ====
package eth_rx_pkg;

	//////////////////////////////////////////////////
	// Bus field widths

	// One MAC data word
	localparam int WORD_BITS = 32;

	// Valid byte count, 1 to 4, with 0 kept for the delimiter
	localparam int BYTE_COUNT_BITS = 3;

	// Statistics counter width
	localparam int PERF_BITS = 64;

	//////////////////////////////////////////////////
	// Typedefs

	typedef logic [WORD_BITS-1:0]       rx_word_t;
	typedef logic [BYTE_COUNT_BITS-1:0] byte_count_t;

	// Stored entry is {byte count, data word}
	typedef logic [BYTE_COUNT_BITS+WORD_BITS-1:0] fifo_entry_t;

	typedef logic [PERF_BITS-1:0] perf_count_t;

	// All-zero entry written at each frame start
	localparam fifo_entry_t DELIMITER_ENTRY = '0;

endpackage

// ==== source/rx_reset_sync.sv ====
module rx_reset_sync (
	input  logic clk,
	input  logic arst_n,
	output logic rst_n
);

	// First stage of the release chain
	logic rst_meta;

	// Assert at once, release after two clk edges
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rst_meta <= 1'b0;
			rst_n    <= 1'b0;
		end else begin
			rst_meta <= 1'b1;
			// Second flop settles any metastable release
			rst_n    <= rst_meta;
		end
	end

endmodule

// ==== source/gray_ptr_sync.sv ====
module gray_ptr_sync #(
	parameter int WIDTH = 11
) (
	input  logic             src_clk,
	input  logic             src_rst_n,
	input  logic             dst_clk,
	input  logic             dst_rst_n,
	input  logic [WIDTH-1:0] src_ptr,
	output logic [WIDTH-1:0] dst_ptr
);

	// Gray copy in the source domain
	logic [WIDTH-1:0] src_gray;

	// Two-flop synchronizer chain in the destination domain
	logic [WIDTH-1:0] dst_meta;
	logic [WIDTH-1:0] dst_gray;

	// Registered so that no glitch crosses the boundary
	always_ff @(posedge src_clk or negedge src_rst_n) begin
		if (!src_rst_n) begin
			src_gray <= '0;
		end else begin
			src_gray <= src_ptr ^ (src_ptr >> 1);
		end
	end

	always_ff @(posedge dst_clk or negedge dst_rst_n) begin
		if (!dst_rst_n) begin
			dst_meta <= '0;
			dst_gray <= '0;
		end else begin
			dst_meta <= src_gray;
			dst_gray <= dst_meta;
		end
	end

	// Back to binary, each bit is the XOR of all Gray bits above it
	always_comb begin
		for (int i = 0; i < WIDTH; i++) begin
			dst_ptr[i] = ^(dst_gray >> i);
		end
	end

endmodule

// ==== source/cdc_packet_fifo.sv ====
module cdc_packet_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 10
) (
	// Write side, MAC receive clock
	input  logic                     wr_clk,
	input  logic                     wr_rst_n,
	input  logic                     wr_en,
	input  eth_rx_pkg::fifo_entry_t  wr_data,
	input  logic                     wr_commit,
	input  logic                     wr_rollback,

	// Read side, system clock
	input  logic                     rd_clk,
	input  logic                     rd_rst_n,
	input  logic                     rd_en,
	input  logic                     rd_pop,
	output eth_rx_pkg::fifo_entry_t  rd_data,
	output logic [FIFO_DEPTH_LOG2:0] rd_size
);

	import eth_rx_pkg::*;

	localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
	localparam int PTR_W = FIFO_DEPTH_LOG2 + 1;

	// Pointers carry one wrap bit above the address
	typedef logic [PTR_W-1:0] ptr_t;

	fifo_entry_t mem [DEPTH];

	// Write domain state
	ptr_t wr_ptr;
	ptr_t commit_ptr;
	ptr_t rd_ptr_wr;
	logic overflow;

	// Write domain decode
	ptr_t wr_fill;
	ptr_t wr_ptr_next;
	logic wr_full;
	logic wr_accept;
	logic overflow_next;
	logic wr_discard;

	// Read domain state
	ptr_t rd_ptr;
	ptr_t commit_ptr_rd;

	//////////////////////////////////////////////////
	// Write side

	// Fill is measured against a stale read pointer, so it errs on the full side
	assign wr_fill   = wr_ptr - rd_ptr_wr;
	assign wr_full   = (wr_fill == ptr_t'(DEPTH));
	assign wr_accept = wr_en && !wr_full && !overflow;

	assign wr_ptr_next = wr_ptr + ptr_t'(wr_accept);

	// Sticky until the frame is closed one way or the other
	assign overflow_next = overflow || (wr_en && wr_full);

	// Drop, or a commit of a frame that did not fit
	assign wr_discard = wr_rollback || (wr_commit && overflow_next);

	always_ff @(posedge wr_clk or negedge wr_rst_n) begin
		if (!wr_rst_n) begin
			wr_ptr     <= '0;
			commit_ptr <= '0;
			overflow   <= 1'b0;
		end else if (wr_discard) begin
			// Throw away everything since the last commit, delimiter included
			wr_ptr     <= commit_ptr;
			overflow   <= 1'b0;
		end else if (wr_commit) begin
			wr_ptr     <= wr_ptr_next;
			commit_ptr <= wr_ptr_next;
			overflow   <= 1'b0;
		end else begin
			wr_ptr     <= wr_ptr_next;
			overflow   <= overflow_next;
		end
	end

	// Tentative writes land in memory but stay invisible until committed
	always_ff @(posedge wr_clk) begin
		if (wr_accept) begin
			mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// Pointer crossings

	// Committed pointer into the read domain
	gray_ptr_sync #(
		.WIDTH(PTR_W)
	) u_commit_sync (
		.src_clk   (wr_clk),
		.src_rst_n (wr_rst_n),
		.dst_clk   (rd_clk),
		.dst_rst_n (rd_rst_n),
		.src_ptr   (commit_ptr),
		.dst_ptr   (commit_ptr_rd)
	);

	// Read pointer back to the write side for the full check
	gray_ptr_sync #(
		.WIDTH(PTR_W)
	) u_read_sync (
		.src_clk   (rd_clk),
		.src_rst_n (rd_rst_n),
		.dst_clk   (wr_clk),
		.dst_rst_n (wr_rst_n),
		.src_ptr   (rd_ptr),
		.dst_ptr   (rd_ptr_wr)
	);

	//////////////////////////////////////////////////
	// Read side

	// Only committed entries count, so a frame is whole before it is read
	assign rd_size = commit_ptr_rd - rd_ptr;

	always_ff @(posedge rd_clk or negedge rd_rst_n) begin
		if (!rd_rst_n) begin
			rd_ptr <= '0;
		end else if (rd_pop) begin
			rd_ptr <= rd_ptr + ptr_t'(1);
		end
	end

	// Registered read, data valid the cycle after rd_en
	always_ff @(posedge rd_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];
		end
	end

endmodule

// ==== source/rx_cdc_pop.sv ====
module rx_cdc_pop #(
	parameter int FIFO_DEPTH_LOG2 = 10
) (
	// MAC side, receive clock
	input  logic                     rx_clk,
	input  logic                     rx_rst_n,
	input  logic                     mac_start,
	input  logic                     mac_data_valid,
	input  eth_rx_pkg::byte_count_t  mac_bytes_valid,
	input  eth_rx_pkg::rx_word_t     mac_data,
	input  logic                     mac_commit,
	input  logic                     mac_drop,

	// FIFO write port
	output logic                     fifo_wr_en,
	output eth_rx_pkg::fifo_entry_t  fifo_wr_data,
	output logic                     fifo_wr_commit,
	output logic                     fifo_wr_rollback,

	// System clock
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,

	// FIFO read port
	input  eth_rx_pkg::fifo_entry_t  fifo_rd_data,
	input  logic [FIFO_DEPTH_LOG2:0] fifo_rd_size,
	output logic                     fifo_rd_en,
	output logic                     fifo_rd_pop,

	// Frames toward the layer-2 decoder
	output logic                     cdc_start,
	output logic                     cdc_data_valid,
	output eth_rx_pkg::byte_count_t  cdc_bytes_valid,
	output eth_rx_pkg::rx_word_t     cdc_data,
	output logic                     cdc_commit
);

	import eth_rx_pkg::*;

	typedef enum logic [2:0] {
		wait_header_req,
		wait_header_lat,
		wait_header_chk,
		idle,
		packet_req,
		packet_data,
		packet_end
	} pop_state_t;

	pop_state_t  state;

	// Fields of the entry on the FIFO read register
	byte_count_t rd_bytes;
	rx_word_t    rd_word;
	logic        rd_is_delim;
	logic        fifo_has_data;

	// Read and pop always go together
	logic        rd_take;

	//////////////////////////////////////////////////
	// Push side

	// One cycle of delay on every strobe keeps commit behind the last write
	always_ff @(posedge rx_clk or negedge rx_rst_n) begin
		if (!rx_rst_n) begin
			fifo_wr_en       <= 1'b0;
			fifo_wr_commit   <= 1'b0;
			fifo_wr_rollback <= 1'b0;
		end else begin
			fifo_wr_en       <= mac_start | mac_data_valid;
			fifo_wr_commit   <= mac_commit;
			fifo_wr_rollback <= mac_drop;
		end
	end

	// Start never shares a cycle with data
	always_ff @(posedge rx_clk) begin
		if (mac_start) begin
			fifo_wr_data <= DELIMITER_ENTRY;
		end else if (mac_data_valid) begin
			fifo_wr_data <= {mac_bytes_valid, mac_data};
		end
	end

	//////////////////////////////////////////////////
	// Pop side

	assign {rd_bytes, rd_word} = fifo_rd_data;
	assign rd_is_delim         = (rd_bytes == '0);
	assign fifo_has_data       = (fifo_rd_size != '0);

	// Next read is chosen after seeing the current entry, never past a delimiter
	always_comb begin
		case (state)
			wait_header_lat: rd_take = 1'b1;
			packet_req:      rd_take = 1'b1;
			packet_data:     rd_take = !rd_is_delim && fifo_has_data;
			default:         rd_take = 1'b0;
		endcase
	end

	assign fifo_rd_en  = rd_take;
	assign fifo_rd_pop = rd_take;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state          <= wait_header_req;
			cdc_start      <= 1'b0;
			cdc_data_valid <= 1'b0;
			cdc_commit     <= 1'b0;
		end else begin
			cdc_start      <= 1'b0;
			cdc_data_valid <= 1'b0;
			cdc_commit     <= 1'b0;
			case (state)
				// Look for the delimiter of the next frame
				wait_header_req: begin
					if (fifo_has_data) begin
						state <= wait_header_lat;
					end
				end
				wait_header_lat: begin
					state <= wait_header_chk;
				end
				// Anything other than a delimiter is junk and gets dropped
				wait_header_chk: begin
					state <= rd_is_delim ? idle : wait_header_req;
				end
				// Delimiter already consumed, any data means a whole frame
				idle: begin
					if (fifo_has_data) begin
						cdc_start <= 1'b1;
						state     <= packet_req;
					end
				end
				packet_req: begin
					state <= packet_data;
				end
				packet_data: begin
					if (rd_is_delim) begin
						// Next frame is queued behind, close this one
						cdc_commit <= 1'b1;
						state      <= idle;
					end else begin
						cdc_data_valid <= 1'b1;
						if (!fifo_has_data) begin
							state <= packet_end;
						end
					end
				end
				// FIFO ran dry after the last word
				packet_end: begin
					cdc_commit <= 1'b1;
					state      <= wait_header_req;
				end
				default: begin
					state <= wait_header_req;
				end
			endcase
		end
	end

	// Word payload, qualified by cdc_data_valid
	always_ff @(posedge sys_clk) begin
		if ((state == packet_data) && !rd_is_delim) begin
			cdc_bytes_valid <= rd_bytes;
			cdc_data        <= rd_word;
		end
	end

endmodule

// ==== source/rx_cdc_counters.sv ====
module rx_cdc_counters (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    cdc_data_valid,
	input  logic                    cdc_commit,
	input  logic                    perf_clear,
	output eth_rx_pkg::perf_count_t perf_frames,
	output eth_rx_pkg::perf_count_t perf_words
);

	//////////////////////////////////////////////////
	// Delivered frame count

	// Clear takes priority over a commit in the same cycle
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			perf_frames <= '0;
		end else if (perf_clear) begin
			perf_frames <= '0;
		end else if (cdc_commit) begin
			perf_frames <= perf_frames + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Delivered word count

	// One per output data strobe
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			perf_words <= '0;
		end else if (perf_clear) begin
			perf_words <= '0;
		end else if (cdc_data_valid) begin
			perf_words <= perf_words + 1'b1;
		end
	end

endmodule

// ==== source/eth_rx_cdc_top.sv ====
module eth_rx_cdc_top #(
	parameter int FIFO_DEPTH_LOG2 = 10
) (
	input  logic                    sys_clk,
	input  logic                    rx_clk,
	input  logic                    arst_n,

	// MAC receive bus
	input  logic                    mac_start,
	input  logic                    mac_data_valid,
	input  eth_rx_pkg::byte_count_t mac_bytes_valid,
	input  eth_rx_pkg::rx_word_t    mac_data,
	input  logic                    mac_commit,
	input  logic                    mac_drop,

	// Decoder side
	output logic                    cdc_start,
	output logic                    cdc_data_valid,
	output eth_rx_pkg::byte_count_t cdc_bytes_valid,
	output eth_rx_pkg::rx_word_t    cdc_data,
	output logic                    cdc_commit,

	// Statistics
	input  logic                    perf_clear,
	output eth_rx_pkg::perf_count_t perf_frames,
	output eth_rx_pkg::perf_count_t perf_words
);

	import eth_rx_pkg::*;

	logic                     rx_rst_n;
	logic                     sys_rst_n;

	logic                     fifo_wr_en;
	fifo_entry_t              fifo_wr_data;
	logic                     fifo_wr_commit;
	logic                     fifo_wr_rollback;
	logic                     fifo_rd_en;
	logic                     fifo_rd_pop;
	fifo_entry_t              fifo_rd_data;
	logic [FIFO_DEPTH_LOG2:0] fifo_rd_size;

	//////////////////////////////////////////////////
	// Per-domain resets

	rx_reset_sync u_rx_rst_sync (
		.clk    (rx_clk),
		.arst_n (arst_n),
		.rst_n  (rx_rst_n)
	);

	rx_reset_sync u_sys_rst_sync (
		.clk    (sys_clk),
		.arst_n (arst_n),
		.rst_n  (sys_rst_n)
	);

	//////////////////////////////////////////////////
	// Packet FIFO

	cdc_packet_fifo #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
	) u_fifo (
		.wr_clk      (rx_clk),
		.wr_rst_n    (rx_rst_n),
		.wr_en       (fifo_wr_en),
		.wr_data     (fifo_wr_data),
		.wr_commit   (fifo_wr_commit),
		.wr_rollback (fifo_wr_rollback),
		.rd_clk      (sys_clk),
		.rd_rst_n    (sys_rst_n),
		.rd_en       (fifo_rd_en),
		.rd_pop      (fifo_rd_pop),
		.rd_data     (fifo_rd_data),
		.rd_size     (fifo_rd_size)
	);

	//////////////////////////////////////////////////
	// Push mapping and pop FSM

	rx_cdc_pop #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
	) u_pop (
		.rx_clk           (rx_clk),
		.rx_rst_n         (rx_rst_n),
		.mac_start        (mac_start),
		.mac_data_valid   (mac_data_valid),
		.mac_bytes_valid  (mac_bytes_valid),
		.mac_data         (mac_data),
		.mac_commit       (mac_commit),
		.mac_drop         (mac_drop),
		.fifo_wr_en       (fifo_wr_en),
		.fifo_wr_data     (fifo_wr_data),
		.fifo_wr_commit   (fifo_wr_commit),
		.fifo_wr_rollback (fifo_wr_rollback),
		.sys_clk          (sys_clk),
		.sys_rst_n        (sys_rst_n),
		.fifo_rd_data     (fifo_rd_data),
		.fifo_rd_size     (fifo_rd_size),
		.fifo_rd_en       (fifo_rd_en),
		.fifo_rd_pop      (fifo_rd_pop),
		.cdc_start        (cdc_start),
		.cdc_data_valid   (cdc_data_valid),
		.cdc_bytes_valid  (cdc_bytes_valid),
		.cdc_data         (cdc_data),
		.cdc_commit       (cdc_commit)
	);

	// Watches the output strobes
	rx_cdc_counters u_counters (
		.sys_clk        (sys_clk),
		.sys_rst_n      (sys_rst_n),
		.cdc_data_valid (cdc_data_valid),
		.cdc_commit     (cdc_commit),
		.perf_clear     (perf_clear),
		.perf_frames    (perf_frames),
		.perf_words     (perf_words)
	);

endmodule

// ==== tb/eth_rx_cdc_assertions.sv ====
module eth_rx_cdc_assertions (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    cdc_start,
	input  logic                    cdc_data_valid,
	input  eth_rx_pkg::byte_count_t cdc_bytes_valid,
	input  logic                    cdc_commit
);

	// Set between cdc_start and cdc_commit
	logic frame_open;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			frame_open <= 1'b0;
		end else if (cdc_start) begin
			frame_open <= 1'b1;
		end else if (cdc_commit) begin
			frame_open <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Output framing

	// Start stands in a cycle of its own
	start_alone: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		cdc_start |-> !(cdc_data_valid || cdc_commit))
		else $error("cdc_start shares a cycle with cdc_data_valid or cdc_commit");

	// Words only between start and commit
	word_in_frame: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		cdc_data_valid |-> frame_open)
		else $error("cdc_data_valid seen outside a frame");

	// Zero byte count belongs to the delimiter only
	bytes_nonzero: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		cdc_data_valid |-> (cdc_bytes_valid != '0))
		else $error("cdc_bytes_valid is zero on a data word");

endmodule

bind rx_cdc_pop eth_rx_cdc_assertions u_assertions (
	.sys_clk         (sys_clk),
	.sys_rst_n       (sys_rst_n),
	.cdc_start       (cdc_start),
	.cdc_data_valid  (cdc_data_valid),
	.cdc_bytes_valid (cdc_bytes_valid),
	.cdc_commit      (cdc_commit)
);

// ==== tb/eth_rx_cdc_tb.sv ====
module eth_rx_cdc_tb;

	import eth_rx_pkg::*;

	localparam int          FIFO_DEPTH_LOG2 = 6;
	localparam logic [31:0] SEED            = 32'hefd2_8407;
	// Larger than the 64-entry FIFO
	localparam int          OVERSIZE_WORDS  = 70;

	logic        sys_clk;
	logic        rx_clk;
	logic        arst_n;
	logic        mac_start;
	logic        mac_data_valid;
	byte_count_t mac_bytes_valid;
	rx_word_t    mac_data;
	logic        mac_commit;
	logic        mac_drop;
	logic        perf_clear;
	logic        cdc_start;
	logic        cdc_data_valid;
	byte_count_t cdc_bytes_valid;
	rx_word_t    cdc_data;
	logic        cdc_commit;
	perf_count_t perf_frames;
	perf_count_t perf_words;

	// Reference model, expected words in order plus length per frame
	fifo_entry_t exp_words[$];
	int          exp_lens[$];
	fifo_entry_t frame_buf[$];
	perf_count_t model_frames = '0;
	perf_count_t model_words  = '0;

	// Monitor state
	logic        in_frame     = 1'b0;
	int          frame_words  = 0;

	int          error_count  = 0;
	int          check_count  = 0;
	int          errors_before;
	// Words plus gaps planned so far, in rx_clk cycles
	int          budget       = 0;
	int          cycle_count  = 0;

	eth_rx_cdc_top #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
	) u_dut (
		.sys_clk         (sys_clk),
		.rx_clk          (rx_clk),
		.arst_n          (arst_n),
		.mac_start       (mac_start),
		.mac_data_valid  (mac_data_valid),
		.mac_bytes_valid (mac_bytes_valid),
		.mac_data        (mac_data),
		.mac_commit      (mac_commit),
		.mac_drop        (mac_drop),
		.cdc_start       (cdc_start),
		.cdc_data_valid  (cdc_data_valid),
		.cdc_bytes_valid (cdc_bytes_valid),
		.cdc_data        (cdc_data),
		.cdc_commit      (cdc_commit),
		.perf_clear      (perf_clear),
		.perf_frames     (perf_frames),
		.perf_words      (perf_words)
	);

	always #4 sys_clk = ~sys_clk;
	always #5 rx_clk = ~rx_clk;

	//////////////////////////////////////////////////
	// MAC side stimulus

	task automatic drive_rx(input logic start, input logic valid, input byte_count_t bytes,
			input rx_word_t data, input logic commit, input logic drop);
		@(posedge rx_clk);
		mac_start       <= start;
		mac_data_valid  <= valid;
		mac_bytes_valid <= bytes;
		mac_data        <= data;
		mac_commit      <= commit;
		mac_drop        <= drop;
	endtask

	task automatic idle_rx(input int cycles);
		budget += cycles;
		repeat (cycles) begin
			drive_rx(1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
		end
	endtask

	// Lost frames end in commit but overflow, so the model skips them too
	task automatic send_frame(input int n_words, input int max_gap, input bit drop, input bit lost);
		byte_count_t bytes;
		rx_word_t    data;
		frame_buf.delete();
		drive_rx(1'b1, 1'b0, '0, '0, 1'b0, 1'b0);
		for (int i = 0; i < n_words; i++) begin
			idle_rx((max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0);
			budget += 1;
			// Only the last word may be short
			bytes = (i == n_words - 1) ? byte_count_t'(1 + $urandom % 4) : byte_count_t'(4);
			data  = $urandom;
			drive_rx(1'b0, 1'b1, bytes, data, 1'b0, 1'b0);
			frame_buf.push_back({bytes, data});
		end
		drive_rx(1'b0, 1'b0, '0, '0, !drop, drop);
		if (!drop && !lost) begin
			foreach (frame_buf[i]) begin
				exp_words.push_back(frame_buf[i]);
			end
			exp_lens.push_back(n_words);
			model_frames += perf_count_t'(1);
			model_words  += perf_count_t'(n_words);
		end
	endtask

	// Let every expected frame out, then leave room for a stray one
	task automatic wait_drain();
		idle_rx(1);
		while (exp_lens.size() != 0 || in_frame) begin
			@(posedge sys_clk);
		end
		repeat (40) @(posedge sys_clk);
	endtask

	//////////////////////////////////////////////////
	// Counters and reporting

	task automatic clear_counters();
		@(posedge sys_clk);
		perf_clear <= 1'b1;
		@(posedge sys_clk);
		perf_clear <= 1'b0;
		model_frames = '0;
		model_words  = '0;
	endtask

	task automatic check_counters(input perf_count_t exp_frames, input perf_count_t exp_count);
		@(negedge sys_clk);
		check_count += 2;
		if (perf_frames !== exp_frames) begin
			error_count++;
			$display("MISMATCH perf_frames: got %h, expected %h", perf_frames, exp_frames);
		end
		if (perf_words !== exp_count) begin
			error_count++;
			$display("MISMATCH perf_words: got %h, expected %h", perf_words, exp_count);
		end
	endtask

	task automatic report_test(input int num, input string name, input int errors_at_start);
		int errs;
		errs = error_count - errors_at_start;
		if (errs == 0) begin
			$display("test %0d, %s: ok", num, name);
		end else begin
			$display("test %0d, %s: %0d errors", num, name, errs);
		end
	endtask

	//////////////////////////////////////////////////
	// Output monitor

	// Sampled on the falling edge, away from the DUT's register updates
	always @(negedge sys_clk) begin : output_monitor
		fifo_entry_t exp_entry;
		int          exp_len;
		if (cdc_start) begin
			if (in_frame) begin
				error_count++;
				$display("cdc_start arrived while a frame was still open");
			end
			in_frame    = 1'b1;
			frame_words = 0;
		end
		if (cdc_data_valid) begin
			if (!in_frame || exp_words.size() == 0) begin
				error_count++;
				$display("output word arrived with no frame open or no word expected");
			end else begin
				exp_entry = exp_words.pop_front();
				frame_words++;
				check_count += 2;
				if (cdc_bytes_valid !== exp_entry[WORD_BITS +: BYTE_COUNT_BITS]) begin
					error_count++;
					$display("MISMATCH cdc_bytes_valid: got %h, expected %h",
						cdc_bytes_valid, exp_entry[WORD_BITS +: BYTE_COUNT_BITS]);
				end
				if (cdc_data !== exp_entry[WORD_BITS-1:0]) begin
					error_count++;
					$display("MISMATCH cdc_data: got %h, expected %h",
						cdc_data, exp_entry[WORD_BITS-1:0]);
				end
			end
		end
		if (cdc_commit) begin
			if (!in_frame || exp_lens.size() == 0) begin
				error_count++;
				$display("cdc_commit arrived with no frame open or no frame expected");
			end else begin
				exp_len = exp_lens.pop_front();
				check_count++;
				if (frame_words != exp_len) begin
					error_count++;
					$display("MISMATCH frame word count: got %h, expected %h",
						frame_words, exp_len);
				end
			end
			in_frame = 1'b0;
		end
	end

	// Limit grows with every planned word and gap
	always @(posedge sys_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= budget * 4 + 2000) begin
			$display("timeout after %0d sys_clk cycles, output never drained", cycle_count);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		void'($urandom(SEED));
		sys_clk         = 1'b0;
		rx_clk          = 1'b0;
		arst_n          = 1'b0;
		mac_start       = 1'b0;
		mac_data_valid  = 1'b0;
		mac_bytes_valid = '0;
		mac_data        = '0;
		mac_commit      = 1'b0;
		mac_drop        = 1'b0;
		perf_clear      = 1'b0;
		repeat (2) @(posedge sys_clk);
		arst_n <= 1'b1;
		repeat (5) @(posedge rx_clk);

		// Random frames with random gaps
		errors_before = error_count;
		for (int f = 0; f < 40; f++) begin
			send_frame(1 + int'($urandom % 20), 5, 1'b0, 1'b0);
			idle_rx(int'($urandom % 6));
		end
		wait_drain();
		report_test(1, "random frames", errors_before);

		// Drops, one short and one long, among good frames
		errors_before = error_count;
		send_frame(1 + int'($urandom % 20), 3, 1'b0, 1'b0);
		send_frame(3, 2, 1'b1, 1'b0);
		send_frame(1 + int'($urandom % 20), 3, 1'b0, 1'b0);
		send_frame(30, 2, 1'b1, 1'b0);
		send_frame(1 + int'($urandom % 20), 3, 1'b0, 1'b0);
		send_frame(1 + int'($urandom % 20), 3, 1'b0, 1'b0);
		wait_drain();
		report_test(2, "dropped frames", errors_before);

		// Short frames back to back so the next delimiter is already queued
		errors_before = error_count;
		for (int f = 0; f < 12; f++) begin
			send_frame(1 + int'($urandom % 2), 0, 1'b0, 1'b0);
		end
		wait_drain();
		report_test(3, "back to back frames", errors_before);

		// Output is idle here, so the oversized frame starts on an empty FIFO
		errors_before = error_count;
		send_frame(OVERSIZE_WORDS, 0, 1'b0, 1'b1);
		send_frame(1 + int'($urandom % 20), 3, 1'b0, 1'b0);
		wait_drain();
		report_test(4, "overflow discard", errors_before);

		// Counters since reset, after clear, then over five more frames
		errors_before = error_count;
		check_counters(model_frames, model_words);
		clear_counters();
		check_counters('0, '0);
		for (int f = 0; f < 5; f++) begin
			send_frame(1 + int'($urandom % 20), 3, 1'b0, 1'b0);
		end
		wait_drain();
		check_counters(model_frames, model_words);
		report_test(5, "performance counters", errors_before);

		$display("tests 5, checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== all.f ====
source/eth_rx_pkg.sv
source/rx_reset_sync.sv
source/gray_ptr_sync.sv
source/cdc_packet_fifo.sv
source/rx_cdc_pop.sv
source/rx_cdc_counters.sv
source/eth_rx_cdc_top.sv
tb/eth_rx_cdc_assertions.sv
tb/eth_rx_cdc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the Verilator model from the file list, run it, look for the pass line
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module eth_rx_cdc_tb -o eth_rx_cdc_sim \
	&& ./obj_dir/eth_rx_cdc_sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
	&& echo "run.sh: simulation ok" \
	|| { echo "run.sh: simulation did not pass"; exit 1; }
